//--- Bender.yml
package:
  name: spi_multi

sources:
  - source/spi_pkg.sv
  - source/apb_spi_regs.sv
  - source/spi_channel.sv
  - source/spi_result_collect.sv
  - source/spi_multi_top.sv
  - target: simulation
    files:
      - verification/spi_slave_model.sv
      - verification/tb_spi_multi.sv

//--- build.f
source/spi_pkg.sv
source/apb_spi_regs.sv
source/spi_channel.sv
source/spi_result_collect.sv
source/spi_multi_top.sv
verification/spi_slave_model.sv
verification/tb_spi_multi.sv

//--- source/apb_spi_regs.sv
module apb_spi_regs (
    input  logic                                                       inner_clk,
    input  logic                                                       reset,
    input  logic                                                       psel,
    input  logic                                                       penable,
    input  logic                                                       pwrite,
    input  logic [spi_pkg::addr_width-1:0]                             paddr,
    input  logic [spi_pkg::pdata_width-1:0]                            pwdata,
    input  logic [spi_pkg::num_channels-1:0]                           busy,
    input  logic [spi_pkg::num_channels-1:0]                           done_flags,
    input  logic [spi_pkg::num_channels-1:0][spi_pkg::data_width-1:0] rx_words,
    output logic [spi_pkg::pdata_width-1:0]                            prdata,
    output logic                                                       pready,
    output logic                                                       pslverr,
    output logic [spi_pkg::num_channels-1:0][spi_pkg::data_width-1:0] tx_data,
    output logic [spi_pkg::div_width-1:0]                              divisor,
    output logic [spi_pkg::num_channels-1:0]                           start,
    output logic [spi_pkg::num_channels-1:0]                           clear_done,
    output logic [spi_pkg::num_channels-1:0]                           irq_en
);
    import spi_pkg::*;

    reg_sel_e                sel;
    logic [ch_idx_width-1:0] ch_idx;
    logic                    access;
    logic                    wr_en;

    assign ch_idx = paddr[ch_idx_width+1:2];      // Word index inside tx/rx window
    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign pready = 1'b1;                         // No wait states

    // Address decode, shared by read and write paths
    always_comb begin
        sel = sel_invalid;
        if (paddr[1:0] == 2'b00) begin
            if (paddr == reg_ctrl) begin
                sel = sel_ctrl;
            end else if (paddr == reg_status) begin
                sel = sel_status;
            end else if (paddr == reg_divisor) begin
                sel = sel_divisor;
            end else if (paddr == reg_irq_en) begin
                sel = sel_irq_en;
            end else if (paddr[addr_width-1:4] == reg_tx_base[addr_width-1:4]) begin
                sel = sel_tx;
            end else if (paddr[addr_width-1:4] == reg_rx_base[addr_width-1:4]) begin
                sel = sel_rx;
            end
        end
    end

    // Unmapped address, or software trying to write a received word
    assign pslverr = access & ((sel == sel_invalid) | (pwrite & (sel == sel_rx)));

    // Control registers and one-cycle command pulses
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            divisor    <= '0;
            irq_en     <= '0;
            start      <= '0;
            clear_done <= '0;
        end else begin
            start      <= '0;
            clear_done <= '0;
            if (wr_en) begin
                case (sel)
                    sel_ctrl:    start      <= pwdata[num_channels-1:0] & ~busy;  // Busy drops it
                    sel_status:  clear_done <= pwdata[num_channels-1:0];          // W1C
                    sel_divisor: divisor    <= pwdata[div_width-1:0];
                    sel_irq_en:  irq_en     <= pwdata[num_channels-1:0];
                    default:     ;
                endcase
            end
        end
    end

    // Transmit words
    always_ff @(posedge inner_clk) begin
        if (wr_en && sel == sel_tx) begin
            tx_data[ch_idx] <= pwdata[data_width-1:0];
        end
    end

    // Read mux, valid during the access cycle
    always_comb begin
        prdata = '0;
        case (sel)
            sel_status: begin
                prdata[num_channels-1:0]              = done_flags;
                prdata[2*num_channels-1:num_channels] = busy;
            end
            sel_divisor: prdata[div_width-1:0]    = divisor;
            sel_irq_en:  prdata[num_channels-1:0] = irq_en;
            sel_tx:      prdata[data_width-1:0]   = tx_data[ch_idx];
            sel_rx:      prdata[data_width-1:0]   = rx_words[ch_idx];
            default:     prdata = '0;             // ctrl reads back zero
        endcase
    end

endmodule

//--- source/spi_channel.sv
module spi_channel (
    input  logic                           inner_clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [spi_pkg::data_width-1:0] tx_data,
    input  logic [spi_pkg::div_width-1:0]  divisor,
    input  logic                           miso,
    output logic                           sclk,
    output logic                           mosi,
    output logic                           cs_n,
    output logic                           busy,
    output logic [spi_pkg::data_width-1:0] rx_data,
    output logic                           done
);
    import spi_pkg::*;

    spi_state_e                 state;
    logic [data_width-1:0]      tx_shift;
    logic [data_width-1:0]      rx_shift;
    logic [bit_count_width-1:0] bit_cnt;
    logic [div_width-1:0]       div_cnt;
    logic [div_width-1:0]       div_hold;    // Divisor frozen for the transfer
    logic                       half_tick;
    logic                       bit_end;

    assign half_tick = (div_cnt == div_hold);
    assign bit_end   = (state == st_transfer) & half_tick & ~sclk;  // End of low half

    assign mosi    = tx_shift[0] & ~cs_n;     // LSB first, low while deselected
    assign busy    = (state != st_idle);
    assign rx_data = rx_shift;

    // FSM, SCLK and chip select
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            sclk    <= 1'b0;
            cs_n    <= 1'b1;
            done    <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        bit_cnt <= bit_count_width'(data_width - 1);
                        state   <= st_select;
                    end
                end

                st_select: begin
                    cs_n    <= 1'b0;
                    sclk    <= 1'b1;          // First bit starts with SCLK high
                    div_cnt <= '0;
                    state   <= st_transfer;
                end

                st_transfer: begin
                    if (half_tick) begin
                        div_cnt <= '0;
                        if (sclk) begin
                            sclk <= 1'b0;     // Slave samples here
                        end else if (bit_cnt == '0) begin
                            cs_n  <= 1'b1;    // SCLK stays low
                            state <= st_done;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                            sclk    <= 1'b1;  // Next bit, MOSI shifts now
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end

                st_done: begin
                    done  <= 1'b1;
                    state <= st_idle;
                end

                default: state <= st_idle;
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge inner_clk) begin
        if (state == st_idle && start) begin
            tx_shift <= tx_data;
            div_hold <= divisor;
        end else if (bit_end) begin
            tx_shift <= {1'b0, tx_shift[data_width-1:1]};
            rx_shift <= {miso, rx_shift[data_width-1:1]};  // MISO enters at the top
        end
    end

endmodule

//--- source/spi_multi_top.sv
module spi_multi_top (
    input  logic                             inner_clk,
    input  logic                             reset,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [spi_pkg::addr_width-1:0]   paddr,
    input  logic [spi_pkg::pdata_width-1:0]  pwdata,
    output logic [spi_pkg::pdata_width-1:0]  prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic [spi_pkg::num_channels-1:0] sclk,
    output logic [spi_pkg::num_channels-1:0] mosi,
    output logic [spi_pkg::num_channels-1:0] cs_n,
    input  logic [spi_pkg::num_channels-1:0] miso,
    output logic                             irq
);
    import spi_pkg::*;

    logic [num_channels-1:0][data_width-1:0] tx_data;
    logic [num_channels-1:0][data_width-1:0] rx_data;
    logic [num_channels-1:0][data_width-1:0] rx_words;
    logic [div_width-1:0]                    divisor;
    logic [num_channels-1:0]                 start;
    logic [num_channels-1:0]                 busy;
    logic [num_channels-1:0]                 done;
    logic [num_channels-1:0]                 done_flags;
    logic [num_channels-1:0]                 clear_done;
    logic [num_channels-1:0]                 irq_en;

    apb_spi_regs u_regs (
        .inner_clk  (inner_clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .done_flags (done_flags),
        .rx_words   (rx_words),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tx_data    (tx_data),
        .divisor    (divisor),
        .start      (start),
        .clear_done (clear_done),
        .irq_en     (irq_en)
    );

    // One engine per channel, divisor shared
    for (genvar ch = 0; ch < num_channels; ch++) begin : gen_ch
        spi_channel u_channel (
            .inner_clk (inner_clk),
            .reset     (reset),
            .start     (start[ch]),
            .tx_data   (tx_data[ch]),
            .divisor   (divisor),
            .miso      (miso[ch]),
            .sclk      (sclk[ch]),
            .mosi      (mosi[ch]),
            .cs_n      (cs_n[ch]),
            .busy      (busy[ch]),
            .rx_data   (rx_data[ch]),
            .done      (done[ch])
        );
    end

    spi_result_collect u_collect (
        .inner_clk  (inner_clk),
        .reset      (reset),
        .done       (done),
        .rx_data    (rx_data),
        .clear_done (clear_done),
        .irq_en     (irq_en),
        .done_flags (done_flags),
        .rx_words   (rx_words),
        .irq        (irq)
    );

endmodule

//--- source/spi_pkg.sv
package spi_pkg;

    localparam int num_channels    = 4;
    localparam int ch_idx_width    = 2;    // log2 of num_channels
    localparam int data_width      = 16;   // Fixed SPI word
    localparam int div_width       = 8;
    localparam int bit_count_width = 4;
    localparam int addr_width      = 8;
    localparam int pdata_width     = 32;   // APB data bus

    // Register map
    localparam logic [addr_width-1:0] reg_ctrl    = 8'h00;  // Start bits, write only
    localparam logic [addr_width-1:0] reg_status  = 8'h04;  // Done[3:0], busy[7:4]
    localparam logic [addr_width-1:0] reg_divisor = 8'h08;
    localparam logic [addr_width-1:0] reg_irq_en  = 8'h0C;
    localparam logic [addr_width-1:0] reg_tx_base = 8'h10;  // 0x10 + 4n
    localparam logic [addr_width-1:0] reg_rx_base = 8'h20;  // 0x20 + 4n, read only

    // Engine FSM
    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_transfer,
        st_done
    } spi_state_e;

    // Decoded register target
    typedef enum logic [2:0] {
        sel_ctrl,
        sel_status,
        sel_divisor,
        sel_irq_en,
        sel_tx,
        sel_rx,
        sel_invalid
    } reg_sel_e;

endpackage

//--- source/spi_result_collect.sv
module spi_result_collect (
    input  logic                                                       inner_clk,
    input  logic                                                       reset,
    input  logic [spi_pkg::num_channels-1:0]                           done,
    input  logic [spi_pkg::num_channels-1:0][spi_pkg::data_width-1:0] rx_data,
    input  logic [spi_pkg::num_channels-1:0]                           clear_done,
    input  logic [spi_pkg::num_channels-1:0]                           irq_en,
    output logic [spi_pkg::num_channels-1:0]                           done_flags,
    output logic [spi_pkg::num_channels-1:0][spi_pkg::data_width-1:0] rx_words,
    output logic                                                       irq
);
    import spi_pkg::*;

    logic [num_channels-1:0] flags_next;

    // Set beats clear when both land in the same cycle
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            if (done[i]) begin
                flags_next[i] = 1'b1;
            end else if (clear_done[i]) begin
                flags_next[i] = 1'b0;
            end else begin
                flags_next[i] = done_flags[i];
            end
        end
    end

    // Sticky flags and registered interrupt
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            done_flags <= '0;
            irq        <= 1'b0;
        end else begin
            done_flags <= flags_next;
            irq        <= |(done_flags & irq_en);  // One cycle behind the flags
        end
    end

    // Received words, a newer completion overwrites an unread one
    always_ff @(posedge inner_clk) begin
        for (int i = 0; i < num_channels; i++) begin
            if (done[i]) begin
                rx_words[i] <= rx_data[i];
            end
        end
    end

endmodule

//--- verification/spi_slave_model.sv
module spi_slave_model (
    input  logic                           sclk,
    input  logic                           mosi,
    input  logic                           cs_n,
    output logic                           miso,
    output logic [spi_pkg::data_width-1:0] captured
);
    import spi_pkg::*;

    assign miso = (cs_n === 1'b0) ? ~mosi : 1'b0;  // Inverse echo while selected

    initial captured = '0;

    // Slave samples MOSI on the falling SCLK edge, LSB arrives first
    always @(negedge sclk) begin
        if (cs_n === 1'b0) begin
            captured <= {mosi, captured[data_width-1:1]};
        end
    end

endmodule

//--- verification/spi_stimulus.txt
# op addr wdata expect, hex, unused fields 0
# wait takes a done mask in wdata, slave and slvrnd take a channel in addr
csn 0 0 F
irq 0 0 0
rd 04 0 0
rd 08 0 0
wr 08 5A 0
rd 08 0 5A
wr 0C F 0
rd 0C 0 F
wr 0C 0 0
# single transfer on channel 0
wr 08 1 0
wr 10 A5C3 0
wr 00 1 0
wait 0 1 0
rd 20 0 5A3C
slave 0 0 A5C3
rd 04 0 1
# all four channels with LCG data
wr 04 F 0
wr 08 2 0
rnd 10 0 0
rnd 14 0 0
rnd 18 0 0
rnd 1C 0 0
wr 00 F 0
wait 0 F 0
rd 04 0 F
rdrnd 20 0 0
rdrnd 24 0 0
rdrnd 28 0 0
rdrnd 2C 0 0
slvrnd 0 0 0
slvrnd 1 0 0
slvrnd 2 0 0
slvrnd 3 0 0
# start to busy channel 1 is dropped
wr 04 F 0
wr 08 1 0
wr 14 1357 0
wr 00 2 0
wr 14 BEEF 0
wr 00 2 0
wait 0 2 0
rd 24 0 ECA8
slave 1 0 1357
# interrupt on channel 2
wr 04 F 0
wr 0C 4 0
wr 18 0F0F 0
wr 00 4 0
wait 0 4 0
irq 0 0 1
wr 04 4 0
irq 0 0 0
wr 0C 0 0
wr 00 4 0
wait 0 4 0
irq 0 0 0
rd 28 0 F0F0
# slave error responses
rderr 30 0 1
wrerr 24 1234 1
wrerr 06 0 1
rderr 20 0 0
csn 0 0 F

//--- verification/tb_spi_multi.sv
module tb_spi_multi;
    import spi_pkg::*;

    localparam int half_period  = 20;
    localparam int reset_cycles = 3;

    logic                     inner_clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [addr_width-1:0]    paddr;
    logic [pdata_width-1:0]   pwdata;
    logic [pdata_width-1:0]   prdata;
    logic                     pready;
    logic                     pslverr;
    logic [num_channels-1:0]  sclk;
    logic [num_channels-1:0]  mosi;
    logic [num_channels-1:0]  cs_n;
    logic [num_channels-1:0]  miso;
    logic                     irq;
    logic [data_width-1:0]    captured [num_channels];
    logic [data_width-1:0]    rnd_words [num_channels];  // Last LCG word per channel
    logic [31:0]              rng_state;
    longint                   cycle_count;
    longint                   cycle_limit;
    string                    ops [$];
    logic [31:0]              addrs [$];
    logic [31:0]              wdatas [$];
    logic [31:0]              expects [$];

    spi_multi_top UUT (
        .inner_clk (inner_clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .miso      (miso),
        .irq       (irq)
    );

    for (genvar ch = 0; ch < num_channels; ch++) begin : gen_slave
        spi_slave_model u_slave (
            .sclk     (sclk[ch]),
            .mosi     (mosi[ch]),
            .cs_n     (cs_n[ch]),
            .miso     (miso[ch]),
            .captured (captured[ch])
        );
    end

    always #half_period inner_clk = ~inner_clk;

    always @(posedge inner_clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped after timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge inner_clk);
        psel    = 1'b1;                    // Setup cycle
        pwrite  = 1'b1;
        paddr   = addr[addr_width-1:0];
        pwdata  = data;
        @(negedge inner_clk);
        penable = 1'b1;                    // Access cycle
        #(half_period / 2);
        err = pslverr;
        check_value("apb_write_pready", 32'd1, pready);
        @(negedge inner_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge inner_clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr[addr_width-1:0];
        @(negedge inner_clk);
        penable = 1'b1;
        #(half_period / 2);
        data = prdata;                     // Sampled mid low phase
        err  = pslverr;
        check_value("apb_read_pready", 32'd1, pready);
        @(negedge inner_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          c;
        string       op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        longint      transfers;
        fd = $fopen("verification/spi_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus");
        end
        transfers = 0;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n == 1 && op == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (n == 1) begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                ops.push_back(op);
                addrs.push_back(a);
                wdatas.push_back(d);
                expects.push_back(e);
                if (op == "wr" && a == reg_ctrl) begin
                    transfers += $countones(d[num_channels-1:0]);
                end
            end
        end
        $fclose(fd);
        cycle_limit = transfers * (32 * 256 + 3) + 200 * ops.size() + reset_cycles;
    endtask

    task automatic run_step(input int idx);
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] rd;
        logic        err;
        int          ch;
        op   = ops[idx];
        a    = addrs[idx];
        d    = wdatas[idx];
        e    = expects[idx];
        rd   = '0;
        name = $sformatf("step%0d_%s_0x%0h", idx, op, a);
        case (op)
            "wr": begin
                apb_write(a, d, err);
                check_value({name, "_pslverr"}, 32'd0, err);
            end
            "rd": begin
                apb_read(a, rd, err);
                check_value(name, e, rd);
                check_value({name, "_pslverr"}, 32'd0, err);
            end
            "wrerr": begin
                apb_write(a, d, err);
                check_value(name, e, err);
            end
            "rderr": begin
                apb_read(a, rd, err);
                check_value(name, e, err);
            end
            "wait": begin
                while ((rd & d) != d) begin          // Poll done bits in the mask
                    apb_read(reg_status, rd, err);
                end
            end
            "rnd": begin
                ch = (a - reg_tx_base) >> 2;
                rng_state     = lcg_next(rng_state);
                rnd_words[ch] = rng_state[31:16];
                apb_write(a, rnd_words[ch], err);
                check_value({name, "_pslverr"}, 32'd0, err);
            end
            "rdrnd": begin
                ch = (a - reg_rx_base) >> 2;
                apb_read(a, rd, err);
                check_value(name, {16'h0, ~rnd_words[ch]}, rd);  // Slave echoes inverse
            end
            "slave":  check_value(name, e, captured[a]);
            "slvrnd": check_value(name, rnd_words[a], captured[a]);
            "csn": begin
                @(negedge inner_clk);
                #(half_period / 2);
                check_value(name, e, cs_n);
                check_value({name, "_sclk"}, 32'd0, sclk);   // Idle bus
                check_value({name, "_mosi"}, 32'd0, mosi);
            end
            "irq": begin
                repeat (2) @(negedge inner_clk);  // Clear pulse, flag, then irq register
                #(half_period / 2);
                check_value(name, e, irq);
            end
            default: begin
                $display("Unknown opcode %s in the stimulus file", op);
                $display("SOME TESTS FAILED");
                $fatal(1, "bad stimulus");
            end
        endcase
    endtask

    initial begin
        inner_clk   = 1'b0;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        cycle_count = 0;
        cycle_limit = 0;
        rng_state   = 32'd30;
        load_stimulus();
        repeat (reset_cycles) @(negedge inner_clk);
        reset = 1'b0;
        foreach (ops[i]) begin
            run_step(i);
        end
        @(negedge inner_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
